// ==== fpu_addsub.sv ====
`include "fpu_macros.svh"

module fpu_addsub
  import fpu_pkg::*;
(
  input  unpacked_t a,
  input  unpacked_t b,
  input  logic      subtract,
  output raw_t      raw
);

  unpacked_t   b_eff;
  unpacked_t   x;          // larger magnitude
  unpacked_t   y;
  logic        a_big;
  logic        eff_sub;
  exp_t        diff;
  logic [53:0] y_wide;
  rsig_t       y_shift;
  rsig_t       y_al;
  logic        sticky;
  logic [27:0] sum;
  logic [4:0]  lz;

  always_comb begin
    b_eff      = b;
    b_eff.sign = b.sign ^ subtract;

    a_big = {a.exp, a.sig} >= {b_eff.exp, b_eff.sig};
    x     = a_big ? a : b_eff;
    y     = a_big ? b_eff : a;
    diff  = x.exp - y.exp;

    // align y, shifted-out bits collapse into sticky
    y_wide = {y.sig, 3'b000, 27'b0} >> diff;
    if (diff > exp_t'(27)) begin
      y_shift = '0;
      sticky  = |y.sig;
    end else begin
      y_shift = y_wide[53:27];
      sticky  = |y_wide[26:0];
    end
    y_al = {y_shift[26:1], y_shift[0] | sticky};

    eff_sub = x.sign ^ y.sign;
    if (eff_sub)
      sum = {1'b0, x.sig, 3'b000} - {1'b0, y_al};
    else
      sum = {1'b0, x.sig, 3'b000} + {1'b0, y_al};

    // highest set bit wins
    lz = '0;
    for (int i = 0; i < 27; i++) begin
      if (sum[i])
        lz = 5'(26 - i);
    end

    raw      = '0;
    raw.sign = x.sign;
    if (sum[27]) begin  // carry out, shift right once
      raw.sig = {sum[27:2], sum[1] | sum[0]};
      raw.exp = x.exp + exp_t'(1);
    end else begin
      raw.sig = sum[26:0] << lz;  // zero sum keeps sig 0, round picks the zero sign
      raw.exp = x.exp - exp_t'(lz);
    end

    if (a.is_nan || b.is_nan || (a.is_inf && b_eff.is_inf && (a.sign != b_eff.sign))) begin
      raw.special     = 1'b1;
      raw.special_val = `FPU_CANON_NAN;
      raw.invalid     = a.is_snan || b.is_snan || (a.is_inf && b_eff.is_inf);
    end else if (a.is_inf) begin
      raw.special     = 1'b1;
      raw.special_val = {a.sign, {`FPU_EXP_W{1'b1}}, {`FPU_MAN_W{1'b0}}};
    end else if (b_eff.is_inf) begin
      raw.special     = 1'b1;
      raw.special_val = {b_eff.sign, {`FPU_EXP_W{1'b1}}, {`FPU_MAN_W{1'b0}}};
    end else if (a.is_zero && b_eff.is_zero && (a.sign == b_eff.sign)) begin
      raw.special     = 1'b1;  // like-signed zeros keep their sign
      raw.special_val = {a.sign, {(`FPU_EXP_W+`FPU_MAN_W){1'b0}}};
    end
  end

endmodule

// ==== fpu_ctrl.sv ====
`include "fpu_macros.svh"

module fpu_ctrl
  import fpu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     req_valid,
  output logic     req_ready,
  input  fpu_req_t req,
  output logic     rsp_valid,
  input  logic     rsp_ready,
  output fpu_op_e  op,
  output rm_t      rm,
  output fp32_t    a_word,
  output fp32_t    b_word,
  output logic     mul_start,
  output logic     mul_step,
  input  logic     mul_last,
  output logic     sel_mul,
  output logic     capture
);

  ctrl_state_e state;
  ctrl_state_e state_nx;
  fpu_op_e     dec_op;
  fpu_op_e     op_q;
  fp32_t       a_q;
  fp32_t       b_q;
  rm_t         rm_q;
  logic        accept;

  always_comb begin
    case (req.funct7)
      7'b000_0000: dec_op = OP_ADD;
      7'b000_0100: dec_op = OP_SUB;
      7'b000_1000: dec_op = OP_MUL;
      default:     dec_op = OP_BAD;
    endcase
  end

  assign accept = req_valid && req_ready;

  always_comb begin
    state_nx = state;
    case (state)
      S_IDLE:  if (accept) state_nx = (dec_op == OP_MUL) ? S_MUL : S_ROUND;
      S_MUL:   if (mul_last) state_nx = S_ROUND;
      S_ROUND: state_nx = S_DONE;
      S_DONE:  if (rsp_ready) state_nx = S_IDLE;
      default: state_nx = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
      op_q  <= OP_ADD;
    end else begin
      state <= state_nx;
      if (accept)
        op_q <= dec_op;
    end
  end

  // bad op swaps in a signaling NaN, the adder then returns qNaN with nv
  always_ff @(posedge clk) begin
    if (accept) begin
      a_q  <= (dec_op == OP_BAD) ? fp32_t'(`FPU_SNAN_WORD) : req.a;
      b_q  <= req.b;
      rm_q <= req.rm;
    end
  end

  assign req_ready = (state == S_IDLE);
  assign rsp_valid = (state == S_DONE);
  assign capture   = (state == S_ROUND);
  assign mul_step  = (state == S_MUL);
  assign mul_start = accept && (dec_op == OP_MUL);

  // operands flow through while idle so the multiplier loads on acceptance
  assign a_word  = (state == S_IDLE) ? req.a : a_q;
  assign b_word  = (state == S_IDLE) ? req.b : b_q;
  assign op      = op_q;
  assign rm      = rm_q;
  assign sel_mul = (op_q == OP_MUL);

endmodule

// ==== fpu_macros.svh ====
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

// binary32 field widths
`define FPU_EXP_W 8
`define FPU_MAN_W 23
`define FPU_SIG_W (`FPU_MAN_W + 1)   // fraction plus hidden bit

`define FPU_EXP_BIAS 127

// one iteration per multiplier bit
`define FPU_MUL_STEPS 24

// quiet NaN returned for every invalid case
`define FPU_CANON_NAN 32'h7fc0_0000

// signaling NaN word, fed in for an unsupported funct7
`define FPU_SNAN_WORD 32'h7f80_0001

`endif

// ==== fpu_mul_iter.sv ====
`include "fpu_macros.svh"

module fpu_mul_iter
  import fpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  logic      step,
  input  unpacked_t a,
  input  unpacked_t b,
  output raw_t      raw
);

  logic [2*`FPU_SIG_W-1:0] prod;
  sig_t                    mplr;      // multiplier, consumed lsb first
  logic                    sign_q;
  exp_t                    exp_q;
  logic [`FPU_SIG_W:0]     part_sum;  // upper half plus carry

  assign part_sum = {1'b0, prod[2*`FPU_SIG_W-1:`FPU_SIG_W]}
                  + {1'b0, a.sig & {`FPU_SIG_W{mplr[0]}}};

  always_ff @(posedge clk) begin
    if (rst) begin
      prod   <= '0;
      mplr   <= '0;
      sign_q <= 1'b0;
      exp_q  <= '0;
    end else if (start) begin
      prod   <= '0;
      mplr   <= b.sig;
      sign_q <= a.sign ^ b.sign;
      exp_q  <= a.exp + b.exp - exp_t'(`FPU_EXP_BIAS);
    end else if (step) begin
      prod <= {part_sum, prod[`FPU_SIG_W-1:1]};  // add then shift right
      mplr <= mplr >> 1;
    end
  end

  always_comb begin
    raw      = '0;
    raw.sign = sign_q;
    if (prod[2*`FPU_SIG_W-1]) begin  // product in [2,4)
      raw.sig = {prod[2*`FPU_SIG_W-1:`FPU_SIG_W-2], |prod[`FPU_SIG_W-3:0]};
      raw.exp = exp_q + exp_t'(1);
    end else begin
      raw.sig = {prod[2*`FPU_SIG_W-2:`FPU_SIG_W-3], |prod[`FPU_SIG_W-4:0]};
      raw.exp = exp_q;
    end

    if (a.is_nan || b.is_nan) begin
      raw.special     = 1'b1;
      raw.special_val = `FPU_CANON_NAN;
      raw.invalid     = a.is_snan || b.is_snan;
    end else if ((a.is_zero && b.is_inf) || (a.is_inf && b.is_zero)) begin
      raw.special     = 1'b1;
      raw.special_val = `FPU_CANON_NAN;
      raw.invalid     = 1'b1;
    end else if (a.is_inf || b.is_inf) begin
      raw.special     = 1'b1;
      raw.special_val = {a.sign ^ b.sign, {`FPU_EXP_W{1'b1}}, {`FPU_MAN_W{1'b0}}};
    end else if (a.is_zero || b.is_zero) begin
      raw.special     = 1'b1;
      raw.special_val = {a.sign ^ b.sign, {(`FPU_EXP_W+`FPU_MAN_W){1'b0}}};
    end
  end

endmodule

// ==== fpu_pkg.sv ====
`include "fpu_macros.svh"

package fpu_pkg;

  typedef logic [`FPU_EXP_W+`FPU_MAN_W:0] fp32_t;
  typedef logic signed [`FPU_EXP_W+1:0] exp_t;   // biased, with room for over/underflow
  typedef logic [`FPU_MAN_W:0] sig_t;
  typedef logic [`FPU_MAN_W+3:0] rsig_t;          // sig plus guard, round, sticky
  typedef logic [2:0] rm_t;
  typedef logic [4:0] step_cnt_t;

  typedef enum logic [1:0] {
    OP_ADD,
    OP_SUB,
    OP_MUL,
    OP_BAD
  } fpu_op_e;

  typedef enum logic [1:0] {
    S_IDLE,
    S_MUL,
    S_ROUND,
    S_DONE
  } ctrl_state_e;

  // same bit order as riscv fflags
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fflags_t;

  typedef struct packed {
    fp32_t      a;
    fp32_t      b;
    logic [6:0] funct7;
    rm_t        rm;
  } fpu_req_t;

  typedef struct packed {
    fp32_t   result;
    fflags_t flags;
  } fpu_rsp_t;

  typedef struct packed {
    logic sign;
    exp_t exp;
    sig_t sig;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_snan;
  } unpacked_t;

  typedef struct packed {
    logic  sign;
    exp_t  exp;
    rsig_t sig;         // bit 26 is the hidden bit when nonzero
    logic  special;     // special_val bypasses rounding
    fp32_t special_val;
    logic  invalid;
  } raw_t;

endpackage

// ==== fpu_round.sv ====
`include "fpu_macros.svh"

module fpu_round
  import fpu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  raw_t     raw,
  input  rm_t      rm,
  input  logic     capture,
  output fpu_rsp_t rsp
);

  logic                  lsb;
  logic                  guard;
  logic                  rbit;
  logic                  sticky;
  logic                  inexact;
  logic                  inc;
  logic                  to_inf;
  logic [`FPU_SIG_W:0]   rnd;   // carry plus rounded significand
  logic [`FPU_MAN_W-1:0] frac;
  exp_t                  exp_r;
  fpu_rsp_t              rsp_d;

  assign lsb     = raw.sig[3];
  assign guard   = raw.sig[2];
  assign rbit    = raw.sig[1];
  assign sticky  = raw.sig[0];
  assign inexact = guard | rbit | sticky;

  always_comb begin
    case (rm)
      3'd1:    inc = 1'b0;                      // toward zero
      3'd2:    inc = inexact & raw.sign;        // down
      3'd3:    inc = inexact & ~raw.sign;       // up
      3'd4:    inc = guard;                     // nearest, ties away
      default: inc = guard & (rbit | sticky | lsb);  // nearest even, also 5..7
    endcase

    // overflow result is inf unless the mode rounds toward zero for this sign
    case (rm)
      3'd1:    to_inf = 1'b0;
      3'd2:    to_inf = raw.sign;
      3'd3:    to_inf = ~raw.sign;
      default: to_inf = 1'b1;
    endcase
  end

  assign rnd   = {1'b0, raw.sig[`FPU_MAN_W+3:3]} + inc;
  assign frac  = rnd[`FPU_SIG_W] ? rnd[`FPU_MAN_W:1] : rnd[`FPU_MAN_W-1:0];
  assign exp_r = raw.exp + exp_t'(rnd[`FPU_SIG_W]);  // renormalize on carry

  always_comb begin
    rsp_d = '0;
    if (raw.special) begin
      rsp_d.result   = raw.special_val;
      rsp_d.flags.nv = raw.invalid;
    end else if (raw.sig == '0) begin
      // exact cancellation
      rsp_d.result = {rm == 3'd2, {(`FPU_EXP_W+`FPU_MAN_W){1'b0}}};
    end else if (exp_r >= exp_t'((1 << `FPU_EXP_W) - 1)) begin
      if (to_inf)
        rsp_d.result = {raw.sign, {`FPU_EXP_W{1'b1}}, {`FPU_MAN_W{1'b0}}};
      else
        rsp_d.result = {raw.sign, {(`FPU_EXP_W-1){1'b1}}, 1'b0, {`FPU_MAN_W{1'b1}}};
      rsp_d.flags.of = 1'b1;
      rsp_d.flags.nx = 1'b1;
    end else if (exp_r < exp_t'(1)) begin
      rsp_d.result   = {raw.sign, {(`FPU_EXP_W+`FPU_MAN_W){1'b0}}};  // no subnormal output
      rsp_d.flags.uf = 1'b1;
      rsp_d.flags.nx = 1'b1;
    end else begin
      rsp_d.result   = {raw.sign, exp_r[`FPU_EXP_W-1:0], frac};
      rsp_d.flags.nx = inexact;
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      rsp <= '0;
    else if (capture)
      rsp <= rsp_d;
  end

endmodule

// ==== fpu_step_counter.sv ====
`include "fpu_macros.svh"

module fpu_step_counter
  import fpu_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic load,
  input  logic step,
  output logic last
);

  step_cnt_t count;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (load) begin
      count <= step_cnt_t'(`FPU_MUL_STEPS);
    end else if (step && (count != '0)) begin
      count <= count - 1'b1;
    end
  end

  // final iteration of the multiplier
  assign last = step && (count == step_cnt_t'(1));

endmodule

// ==== fpu_tb_model.svh ====
`ifndef FPU_TB_MODEL_SVH
`define FPU_TB_MODEL_SVH

// {sign, exp, sig, zero, inf, nan, snan}, subnormals flushed to zero
function automatic logic [36:0] split_word(input logic [31:0] w);
  logic zero;
  logic ones;
  zero = (w[30:23] == 8'h00);
  ones = (w[30:23] == 8'hff);
  return {w[31], zero ? 8'h00 : w[30:23], zero ? 24'h0 : {1'b1, w[22:0]},
          zero, ones && (w[22:0] == 0), ones && (w[22:0] != 0), ones && (w[22:0] != 0) && !w[22]};
endfunction

// exponent of the normalized value is e + msb position of m
function automatic logic [36:0] round_pack(input logic sign, input int e, input logic [63:0] m,
                                           input logic sticky, input logic [2:0] rm);
  int         p;
  int         ex;
  logic [24:0] q;
  logic        g;
  logic        rest;
  logic        inc;
  logic        to_inf;
  p = 0;
  for (int i = 0; i < 64; i++)
    if (m[i]) p = i;
  ex = e + p;
  if (p >= 24) begin
    q    = 25'(m >> (p - 23));
    g    = m[p-24];
    rest = |(m & ((64'd1 << (p - 24)) - 1)) | sticky;
  end else begin
    q    = 25'(m << (23 - p));
    g    = 1'b0;
    rest = sticky;
  end
  case (rm)
    3'd1:    inc = 1'b0;
    3'd2:    inc = (g | rest) & sign;
    3'd3:    inc = (g | rest) & ~sign;
    3'd4:    inc = g;
    default: inc = g & (rest | q[0]);
  endcase
  q = q + inc;
  if (q[24]) begin  // carry into a new binade
    q  = q >> 1;
    ex = ex + 1;
  end
  if (ex >= 255) begin
    to_inf = (rm == 3'd1) ? 1'b0 : (rm == 3'd2) ? sign : (rm == 3'd3) ? ~sign : 1'b1;
    if (to_inf)
      return {sign, 8'hff, 23'h0, 5'b00101};
    return {sign, 8'hfe, 23'h7fffff, 5'b00101};
  end
  if (ex < 1)
    return {sign, 31'h0, 5'b00011};
  return {sign, 8'(ex), q[22:0], 4'b0000, g | rest};
endfunction

// expected {result, nv dz of uf nx}
function automatic logic [36:0] model_rsp(input logic [31:0] a, input logic [31:0] b,
                                          input logic [6:0] f7, input logic [2:0] rm);
  logic [36:0] ua;
  logic [36:0] ub;
  logic [36:0] ux;
  logic [36:0] uy;
  logic        sb;
  int          d;
  logic [63:0] xm;
  logic [63:0] yf;
  logic [63:0] yt;
  logic [63:0] m;
  logic        lost;
  if (f7 != 7'h00 && f7 != 7'h04 && f7 != 7'h08)
    return {32'h7fc00000, 5'b10000};
  ua = split_word(a);
  ub = split_word(b);
  if (f7 == 7'h08) begin
    sb = ua[36] ^ ub[36];
    if (ua[1] || ub[1])
      return {32'h7fc00000, ua[0] | ub[0], 4'b0};
    if ((ua[3] && ub[2]) || (ua[2] && ub[3]))
      return {32'h7fc00000, 5'b10000};
    if (ua[2] || ub[2])
      return {sb, 8'hff, 23'h0, 5'b0};
    if (ua[3] || ub[3])
      return {sb, 31'h0, 5'b0};
    return round_pack(sb, int'(ua[35:28]) + int'(ub[35:28]) - 127 - 46,
                      64'(ua[27:4]) * 64'(ub[27:4]), 1'b0, rm);
  end
  ub[36] = ub[36] ^ (f7 == 7'h04);  // subtract flips b
  if (ua[1] || ub[1])
    return {32'h7fc00000, ua[0] | ub[0], 4'b0};
  if (ua[2] && ub[2] && (ua[36] != ub[36]))
    return {32'h7fc00000, 5'b10000};
  if (ua[2])
    return {ua[36], 8'hff, 23'h0, 5'b0};
  if (ub[2])
    return {ub[36], 8'hff, 23'h0, 5'b0};
  if (ua[3] && ub[3])
    return {(ua[36] == ub[36]) ? ua[36] : (rm == 3'd2), 31'h0, 5'b0};
  ux = (ua[35:4] >= ub[35:4]) ? ua : ub;
  uy = (ua[35:4] >= ub[35:4]) ? ub : ua;
  d  = int'(ux[35:28]) - int'(uy[35:28]);
  xm = 64'(ux[27:4]) << 39;
  yf = 64'(uy[27:4]) << 39;
  yt   = (d >= 64) ? 64'h0 : (yf >> d);
  lost = (d >= 64) ? (uy[27:4] != 0) : |(yf & ((64'd1 << d) - 1));
  if (ux[36] ^ uy[36])
    m = xm - yt - 64'(lost);  // borrow for the bits below the window
  else
    m = xm + yt;
  if (m == 0 && !lost)
    return {rm == 3'd2, 31'h0, 5'b0};
  return round_pack(ux[36], int'(ux[35:28]) - 62, m, lost, rm);
endfunction

`endif

// ==== fpu_tb.sv ====
module fpu_tb
  import fpu_pkg::*;
;

  `include "fpu_tb_model.svh"

  localparam int N_DIRECTED = 18;
  localparam int N_RANDOM   = 200;
  localparam int LIMIT      = (N_DIRECTED + N_RANDOM) * 40 + 200;

  logic        clk;
  logic        rst;
  logic        req_valid;
  logic        req_ready;
  fpu_req_t    req;
  logic        rsp_valid;
  logic        rsp_ready;
  fpu_rsp_t    rsp;
  integer      seed;
  int          cycles;
  int          data_errors;
  int          proto_errors;
  int          acc_cycle;
  int          exp_lat;
  logic        busy;
  logic        prev_valid;
  logic        prev_ready;
  fpu_rsp_t    prev_rsp;
  logic [36:0] exp_q[$];

  fpu_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // random back-pressure, ready about three cycles in four
  always @(posedge clk) begin
    if (rst)
      rsp_ready <= 1'b0;
    else
      rsp_ready <= (($random(seed) & 3) != 0);
  end

  function automatic fp32_t rand_word();
    logic [7:0] e;
    e = 8'((($random(seed) & 32'h7fff_ffff) % 255));  // never all ones
    return {1'($random(seed)), e, 23'($random(seed))};
  endfunction

  // caller sits on a rising edge
  task automatic send(input fp32_t a, input fp32_t b, input logic [6:0] f7, input rm_t rm);
    req       <= {a, b, f7, rm};
    req_valid <= 1'b1;
    @(posedge clk);
    while (!req_ready)
      @(posedge clk);
    req_valid <= 1'b0;
  endtask

  // sampled mid-cycle where everything is settled
  always @(negedge clk) begin
    cycles = cycles + 1;
    if (cycles > LIMIT) begin
      $display("timeout after %0d cycles, responses still outstanding", cycles);
      $display("ERRORS FOUND");
      $finish;
    end else if (!rst) begin
      assert (!(busy && req_ready)) else begin
        proto_errors++;
        $display("req_ready is high while a request is still in flight");
      end
      if (prev_valid && !prev_ready) begin
        assert (rsp_valid) else begin
          proto_errors++;
          $display("rsp_valid dropped before the response was taken");
        end
        assert (rsp == prev_rsp) else begin
          data_errors++;
          $display("[FAIL] rsp changed under back-pressure: now %h, was %h", rsp, prev_rsp);
        end
      end
      if (rsp_valid && !prev_valid) begin
        assert (cycles - acc_cycle == exp_lat) else begin
          proto_errors++;
          $display("rsp_valid rose %0d edges after acceptance instead of %0d",
                   cycles - acc_cycle, exp_lat);
        end
      end
      if (req_valid && req_ready) begin
        exp_q.push_back(model_rsp(req.a, req.b, req.funct7, req.rm));
        acc_cycle = cycles + 1;  // handshake lands on the coming edge
        exp_lat   = (req.funct7 == 7'h08) ? 25 : 1;
        busy      = 1'b1;
      end
      if (rsp_valid && rsp_ready) begin
        if (exp_q.size() == 0) begin
          proto_errors++;
          $display("response handed over with no request outstanding");
        end else begin
          assert (rsp == exp_q[0]) else begin
            data_errors++;
            $display("[FAIL] rsp.result got %h expected %h, rsp.flags got %h expected %h",
                     rsp.result, exp_q[0][36:5], rsp.flags, exp_q[0][4:0]);
          end
          exp_q.pop_front();
        end
        busy = 1'b0;
      end
    end
    prev_valid = rsp_valid;
    prev_ready = rsp_ready;
    prev_rsp   = rsp;
  end

  initial begin
    fp32_t      ra;
    fp32_t      rb;
    logic [6:0] f7;
    int         pick;
    seed = 32'h6722_c9a3;
    rst = 1'b1;
    req_valid = 1'b0;
    req = '0;
    rsp_ready = 1'b0;
    cycles = 0;
    data_errors = 0;
    proto_errors = 0;
    acc_cycle = 0;
    exp_lat = 0;
    busy = 1'b0;
    prev_valid = 1'b0;
    prev_ready = 1'b0;
    prev_rsp = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    assert (req_ready && !rsp_valid) else begin
      proto_errors++;
      $display("after reset the unit is not idle with ready high and valid low");
    end

    send(32'h7f80_0000, 32'h7f80_0000, 7'h04, 3'd0);  // inf - inf
    send(32'h0000_0000, 32'hff80_0000, 7'h08, 3'd0);  // 0 * inf
    send(32'h7f80_0001, 32'h3f80_0000, 7'h00, 3'd0);  // snan
    send(32'h0000_0001, 32'h8000_0000, 7'h00, 3'd0);  // subnormals flush
    send(32'h8000_0005, 32'h3f80_0000, 7'h08, 3'd1);
    send(32'h807f_ffff, 32'h3f80_0000, 7'h00, 3'd0);
    send(32'h3f80_0000, 32'h3f80_0000, 7'h04, 3'd2);  // cancel gives -0
    for (int r = 0; r < 5; r++) begin
      send(32'h7f7f_ffff, 32'h4000_0000, 7'h08, rm_t'(r));
      send(32'h8080_0000, 32'h3f00_0000, 7'h08, rm_t'(r));
    end
    send(32'h3f80_0000, 32'h3f80_0000, 7'h10, 3'd0);  // unsupported funct7

    for (int i = 0; i < N_RANDOM; i++) begin
      pick = $random(seed);
      ra = rand_word();
      rb = rand_word();
      if (pick[2])
        rb[30:23] = ra[30:23];  // close exponents for cancellation
      f7 = (pick[1:0] == 2'd0) ? 7'h04 : (pick[1:0] == 2'd1) ? 7'h08 : 7'h00;
      send(ra, rb, f7, rm_t'((($random(seed) & 32'h7fff_ffff) % 5)));
    end

    while (busy || exp_q.size() != 0)
      @(posedge clk);
    repeat (2) @(posedge clk);
    $display("checks done: %0d data errors, %0d protocol errors", data_errors, proto_errors);
    if (data_errors == 0 && proto_errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== fpu_top.f ====
+incdir+.
fpu_pkg.sv
fpu_unpack.sv
fpu_addsub.sv
fpu_step_counter.sv
fpu_mul_iter.sv
fpu_round.sv
fpu_ctrl.sv
fpu_top.sv
fpu_tb.sv

// ==== fpu_top.sv ====
module fpu_top
  import fpu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     req_valid,
  output logic     req_ready,
  input  fpu_req_t req,
  output logic     rsp_valid,
  input  logic     rsp_ready,
  output fpu_rsp_t rsp
);

  fpu_op_e   op;
  rm_t       rm;
  fp32_t     a_word;
  fp32_t     b_word;
  logic      mul_start;
  logic      mul_step;
  logic      mul_last;
  logic      sel_mul;
  logic      capture;
  unpacked_t a_unp;
  unpacked_t b_unp;
  raw_t      raw_as;
  raw_t      raw_mul;

  fpu_ctrl ctrl0 (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .op        (op),
    .rm        (rm),
    .a_word    (a_word),
    .b_word    (b_word),
    .mul_start (mul_start),
    .mul_step  (mul_step),
    .mul_last  (mul_last),
    .sel_mul   (sel_mul),
    .capture   (capture)
  );

  fpu_step_counter cnt0 (
    .clk  (clk),
    .rst  (rst),
    .load (mul_start),
    .step (mul_step),
    .last (mul_last)
  );

  fpu_unpack unp_a (.operand(a_word), .unp(a_unp));
  fpu_unpack unp_b (.operand(b_word), .unp(b_unp));

  fpu_addsub addsub0 (
    .a        (a_unp),
    .b        (b_unp),
    .subtract (op == OP_SUB),
    .raw      (raw_as)
  );

  fpu_mul_iter mul0 (
    .clk   (clk),
    .rst   (rst),
    .start (mul_start),
    .step  (mul_step),
    .a     (a_unp),
    .b     (b_unp),
    .raw   (raw_mul)
  );

  fpu_round round0 (
    .clk     (clk),
    .rst     (rst),
    .raw     (sel_mul ? raw_mul : raw_as),
    .rm      (rm),
    .capture (capture),
    .rsp     (rsp)
  );

endmodule

// ==== fpu_unpack.sv ====
`include "fpu_macros.svh"

module fpu_unpack
  import fpu_pkg::*;
(
  input  fp32_t     operand,
  output unpacked_t unp
);

  logic [`FPU_EXP_W-1:0] exp_field;
  logic [`FPU_MAN_W-1:0] frac;
  logic                  exp_ones;
  logic                  exp_zero;

  assign exp_field = operand[`FPU_EXP_W+`FPU_MAN_W-1:`FPU_MAN_W];
  assign frac      = operand[`FPU_MAN_W-1:0];
  assign exp_ones  = &exp_field;
  assign exp_zero  = ~|exp_field;

  always_comb begin
    unp.sign = operand[`FPU_EXP_W+`FPU_MAN_W];

    // subnormals land here too, flushed to a signed zero
    unp.is_zero = exp_zero;
    unp.is_inf  = exp_ones && (frac == '0);
    unp.is_nan  = exp_ones && (frac != '0);
    unp.is_snan = exp_ones && (frac != '0) && !frac[`FPU_MAN_W-1];  // quiet bit clear

    if (exp_zero) begin
      unp.exp = '0;
      unp.sig = '0;
    end else begin
      unp.exp = exp_t'({2'b00, exp_field});
      unp.sig = {1'b1, frac};  // hidden bit
    end
  end

endmodule
